//--- fetch_pc_gen.sv
////////////////////////////////////////////////////////////
// Next fetch address and F-stage PC
// M branch wins over X branch, X over sequential
// pc_a is combinational, feed it only to registered logic
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_gen #(
    parameter ifu_pkg::pc_t RESET_PC = '0          // Word address of first fetch
) (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            stall_f_i,        // Hold F-stage PC
    input  wire ifu_pkg::branch_t branch_x_i,      // X-stage branch
    input  wire ifu_pkg::branch_t branch_m_i,      // M-stage branch
    output ifu_pkg::pc_t         pc_a_o,           // A-stage fetch address
    output ifu_pkg::pc_t         pc_f_o            // F-stage PC
);

    // One word before the vector, so the first sequential pc_a hits it
    localparam ifu_pkg::pc_t PC_F_RESET = RESET_PC - ifu_pkg::pc_t'(1);

    ifu_pkg::pc_src_e pc_src;                      // Selected source
    ifu_pkg::pc_t     pc_seq;                      // pc_f plus one word
    ifu_pkg::pc_t     pc_f_q;

    ////////////////////////////////////////////////////////////
    // Source select
    ////////////////////////////////////////////////////////////

    assign pc_seq = pc_f_q + ifu_pkg::pc_t'(1);

    // Later stage has priority
    always_comb
    begin
        if (branch_m_i.taken)
            pc_src = ifu_pkg::PC_BRANCH_M;
        else if (branch_x_i.taken)
            pc_src = ifu_pkg::PC_BRANCH_X;
        else
            pc_src = ifu_pkg::PC_SEQ;
    end

    always_comb
    begin
        case (pc_src)
            ifu_pkg::PC_BRANCH_M: pc_a_o = branch_m_i.target;
            ifu_pkg::PC_BRANCH_X: pc_a_o = branch_x_i.target;
            default:              pc_a_o = pc_seq;        // Plain fall-through
        endcase
    end

    ////////////////////////////////////////////////////////////
    // F-stage PC
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            pc_f_q <= PC_F_RESET;
        else if (!stall_f_i)
            pc_f_q <= pc_a_o;                      // Advance with the fetch
    end

    assign pc_f_o = pc_f_q;

    // Fetch address must be known once out of reset, also covers branch targets
    a_pc_a_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(pc_a_o));

endmodule

`default_nettype wire

//--- fetch_result_regs.sv
////////////////////////////////////////////////////////////
// D-stage instruction register and D..W PC tracking
// Each stage loads on its own stall being low
// W has no stall and follows M every cycle
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module fetch_result_regs (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire ifu_pkg::stall_t     stall_i,      // Uses d, x and m
    input  wire ifu_pkg::pc_t        pc_f_i,       // F-stage PC
    input  wire ifu_pkg::fetch_word_t fetch_f_i,   // Word from the bus master
    output ifu_pkg::fetch_word_t     instr_d_o,    // To decode
    output ifu_pkg::stage_pc_t       stage_pc_o
);

    ifu_pkg::fetch_word_t instr_d_q;
    ifu_pkg::stage_pc_t   stage_q;

    ////////////////////////////////////////////////////////////
    // Instruction register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            instr_d_q <= '0;
        else if (!stall_i.d)
            instr_d_q <= fetch_f_i;                // Error flag rides along
    end

    ////////////////////////////////////////////////////////////
    // Stage PCs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            stage_q <= '0;
        end
        else
        begin
            if (!stall_i.d)
                stage_q.pc_d <= pc_f_i;            // Same edge as instr_d
            if (!stall_i.x)
                stage_q.pc_x <= stage_q.pc_d;
            if (!stall_i.m)
                stage_q.pc_m <= stage_q.pc_x;
            stage_q.pc_w <= stage_q.pc_m;          // Never stalls
        end
    end

    assign instr_d_o  = instr_d_q;
    assign stage_pc_o = stage_q;

    // W is a plain one-cycle delay of M
    a_pc_w_follows_m: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) |-> (stage_pc_o.pc_w == $past(stage_pc_o.pc_m)));

endmodule

`default_nettype wire

//--- ifu_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, types and bus structs of the fetch unit
// Bus is word-wide and read-only, no byte lanes or bursts
// PCs are word addresses, byte address is pc followed by 00
////////////////////////////////////////////////////////////
`default_nettype none

package ifu_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int WORD_W     = 32;                 // Bus and instruction width
    localparam int BYTE_OFS_W = 2;                  // Byte offset inside a word
    localparam int PC_W       = WORD_W - BYTE_OFS_W; // Word address width, 30

    typedef logic [PC_W-1:0]   pc_t;                // Word address
    typedef logic [WORD_W-1:0] word_t;              // Bus word or instruction

    ////////////////////////////////////////////////////////////
    // Pipeline side
    ////////////////////////////////////////////////////////////

    // Stall levels from the core, one per stage
    typedef struct packed {
        logic a;
        logic f;
        logic d;
        logic x;
        logic m;
    } stall_t;

    // One branch request from X or M
    typedef struct packed {
        logic taken;
        pc_t  target;
    } branch_t;

    // Instruction plus its fetch error
    typedef struct packed {
        word_t instr;
        logic  bus_error;
    } fetch_word_t;

    // PCs of the later stages
    typedef struct packed {
        pc_t pc_d;
        pc_t pc_x;
        pc_t pc_m;
        pc_t pc_w;
    } stage_pc_t;

    ////////////////////////////////////////////////////////////
    // Wishbone side, classic cycles only
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic [WORD_W-1:0] adr;                     // Byte address
    } wb_req_t;

    typedef struct packed {
        word_t dat;
        logic  ack;
        logic  err;
    } wb_rsp_t;

    // Bus master state
    typedef enum logic {
        FETCH_IDLE = 1'b0,
        FETCH_BUSY = 1'b1
    } fetch_state_e;

    // Where the next fetch address comes from
    typedef enum logic [1:0] {
        PC_SEQ      = 2'd0,
        PC_BRANCH_X = 2'd1,
        PC_BRANCH_M = 2'd2
    } pc_src_e;

endpackage

`default_nettype wire

//--- ifu_stim.txt
// Columns: word err delay branch x_target m_target extra_stalls (all hex)
// branch: 0 none, 1 X, 2 M, 3 both; targets are word addresses
13000000 0 0 0 00000000 00000000 0
13050001 0 2 0 00000000 00000000 1
13060002 0 1 1 00000200 00000300 0
00a50533 0 3 0 00000000 00000000 0
deadbeef 1 1 0 00000000 00000000 0
00b585b3 0 0 0 00000000 00000000 0
0ff00f0f 0 1 0 00000000 00000000 2
fe000ee3 0 0 2 00000400 00000100 0
00112233 0 4 0 00000000 00000000 0
a5a5a5a5 0 2 3 00000500 00000600 1
5a5a5a5a 0 1 0 00000000 00000000 0
badc0de1 1 0 0 00000000 00000000 0
c001d00d 1 2 1 00000700 00000000 0
00000073 0 1 0 00000000 00000000 0
10500073 0 0 3 00000040 00000050 0
30200073 0 5 0 00000000 00000000 3
7fffffff 0 1 1 3ffffffe 00000000 0
80000001 0 0 0 00000000 00000000 1
00000013 0 2 0 00000000 00000000 0
ffffffff 0 1 2 00000010 00000080 0

//--- instruction_unit.f
ifu_pkg.sv
fetch_pc_gen.sv
wb_fetch_master.sv
fetch_result_regs.sv
instruction_unit.sv
tb_instruction_unit.sv

//--- instruction_unit.sv
////////////////////////////////////////////////////////////
// Instruction fetch unit, uncached, classic Wishbone
// Core holds stall a/f/d while cyc is high and releases
// them together for one cycle after cyc falls
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module instruction_unit #(
    parameter ifu_pkg::pc_t RESET_PC = 30'h0000_0040 // Byte address 0x100
) (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    // From the core
    input  wire ifu_pkg::stall_t      stall_i,
    input  wire ifu_pkg::branch_t     branch_x_i,
    input  wire ifu_pkg::branch_t     branch_m_i,
    // Instruction bus
    input  wire ifu_pkg::wb_rsp_t     wb_rsp_i,
    output ifu_pkg::wb_req_t          wb_req_o,
    // To the core
    output ifu_pkg::pc_t              pc_f_o,
    output ifu_pkg::stage_pc_t        stage_pc_o,
    output ifu_pkg::fetch_word_t      instr_d_o
);

    ifu_pkg::pc_t         pc_a;                    // Next fetch address
    ifu_pkg::fetch_word_t fetch_f;                 // F-stage word and error

    ////////////////////////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////////////////////////

    fetch_pc_gen #(
        .RESET_PC   (RESET_PC)
    ) u_pc_gen (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stall_f_i  (stall_i.f),
        .branch_x_i (branch_x_i),
        .branch_m_i (branch_m_i),
        .pc_a_o     (pc_a),
        .pc_f_o     (pc_f_o)
    );

    ////////////////////////////////////////////////////////////
    // Bus read
    ////////////////////////////////////////////////////////////

    // Branch strobes only clear the sticky error here
    wb_fetch_master u_wb_master (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .stall_a_i        (stall_i.a),
        .pc_a_i           (pc_a),
        .branch_x_taken_i (branch_x_i.taken),
        .branch_m_taken_i (branch_m_i.taken),
        .wb_rsp_i         (wb_rsp_i),
        .wb_req_o         (wb_req_o),
        .fetch_f_o        (fetch_f)
    );

    ////////////////////////////////////////////////////////////
    // Decode register and stage PCs
    ////////////////////////////////////////////////////////////

    fetch_result_regs u_result (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .pc_f_i     (pc_f_o),                      // Same net as the port
        .fetch_f_i  (fetch_f),
        .instr_d_o  (instr_d_o),
        .stage_pc_o (stage_pc_o)
    );

endmodule

`default_nettype wire

//--- tb_instruction_unit.sv
////////////////////////////////////////////////////////////
// Self-checking testbench of the fetch unit
// Records come from ifu_stim.txt, one per fetch, 7 words each
// Core model stalls a/f/d while cyc is high, x and m follow d
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_instruction_unit;

    localparam ifu_pkg::pc_t RESET_PC = 30'h0000_0080;  // Byte address 0x200
    localparam int RESET_CYCLES = 16;
    localparam int MAX_RECS     = 32;
    localparam int REC_WORDS    = 7;                     // Words per stimulus record
    localparam int F_WORD  = 0;                          // Field offsets in a record
    localparam int F_ERR   = 1;
    localparam int F_DELAY = 2;
    localparam int F_KIND  = 3;                          // 0 none, 1 X, 2 M, 3 both
    localparam int F_X_TGT = 4;
    localparam int F_M_TGT = 5;
    localparam int F_EXTRA = 6;

    logic                 clk_i;
    logic                 rst_n_i;
    ifu_pkg::stall_t      stall;
    ifu_pkg::branch_t     branch_x;
    ifu_pkg::branch_t     branch_m;
    ifu_pkg::wb_rsp_t     wb_rsp;
    ifu_pkg::wb_req_t     wb_req;
    ifu_pkg::pc_t         pc_f;
    ifu_pkg::stage_pc_t   stage_pc;
    ifu_pkg::fetch_word_t instr_d;

    logic [31:0]  stim_mem [0:MAX_RECS*REC_WORDS-1];   // Unloaded entries stay X
    ifu_pkg::pc_t fetch_q [$];                         // Expected PC of each fetch
    int           cycle_limit = 100000;                // Tightened once records are read
    int           cycle_count = 0;

    instruction_unit #(
        .RESET_PC   (RESET_PC)
    ) DUT (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall),
        .branch_x_i (branch_x),
        .branch_m_i (branch_m),
        .wb_rsp_i   (wb_rsp),
        .wb_req_o   (wb_req),
        .pc_f_o     (pc_f),
        .stage_pc_o (stage_pc),
        .instr_d_o  (instr_d)
    );

    ////////////////////////////////////////////////////////////
    // Compare tasks and helpers
    ////////////////////////////////////////////////////////////

    task automatic check_pc(input string name, input ifu_pkg::pc_t got, input ifu_pkg::pc_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Stopped on first error");
        end
    endtask

    task automatic check_word(input string name, input ifu_pkg::fetch_word_t got,
                              input ifu_pkg::fetch_word_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s got instr=%h err=%b expected instr=%h err=%b",
                     $time, name, got.instr, got.bus_error, exp.instr, exp.bus_error);
            $display("TEST FAILED");
            $fatal(1, "Stopped on first error");
        end
    endtask

    task automatic check_req(input string name, input ifu_pkg::wb_req_t got,
                             input ifu_pkg::wb_req_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s got cyc=%b stb=%b adr=%h expected cyc=%b stb=%b adr=%h",
                     $time, name, got.cyc, got.stb, got.adr, exp.cyc, exp.stb, exp.adr);
            $display("TEST FAILED");
            $fatal(1, "Stopped on first error");
        end
    endtask

    // D, X and M PCs against the shift model
    task automatic expect_stage_pcs(input ifu_pkg::pc_t exp_d, input ifu_pkg::pc_t exp_x,
                                    input ifu_pkg::pc_t exp_m);
        check_pc("stage_pc_o.pc_d", stage_pc.pc_d, exp_d);
        check_pc("stage_pc_o.pc_x", stage_pc.pc_x, exp_x);
        check_pc("stage_pc_o.pc_m", stage_pc.pc_m, exp_m);
    endtask

    function automatic ifu_pkg::wb_req_t bus_read_req(input logic busy, input ifu_pkg::pc_t pc);
        ifu_pkg::wb_req_t req;
        req.cyc = busy;
        req.stb = busy;
        req.adr = {pc, 2'b00};                           // Word to byte address
        return req;
    endfunction

    // Records end at the first unloaded word
    function automatic int count_records();
        int n;
        n = 0;
        while (n < MAX_RECS && !$isunknown(stim_mem[n*REC_WORDS]))
            n++;
        return n;
    endfunction

    ////////////////////////////////////////////////////////////
    // Clock, watchdog and W-stage monitor
    ////////////////////////////////////////////////////////////

    initial
    begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;                      // 40 ns period
    end

    initial
    begin : watchdog
        forever
        begin
            @(posedge clk_i);
            cycle_count++;
            if (cycle_count > cycle_limit)
            begin
                $display("Timeout after %0d cycles, fetch sequence did not finish", cycle_count);
                $display("TEST FAILED");
                $fatal(1, "Watchdog expired");
            end
        end
    end

    // pc_w lags pc_m by one cycle, stalled or not
    initial
    begin : pc_w_monitor
        ifu_pkg::pc_t prev_m;
        @(posedge rst_n_i);
        @(negedge clk_i);
        prev_m = stage_pc.pc_m;
        forever
        begin
            @(negedge clk_i);
            check_pc("stage_pc_o.pc_w", stage_pc.pc_w, prev_m);
            prev_m = stage_pc.pc_m;
        end
    end

    ////////////////////////////////////////////////////////////
    // Core and bus slave model
    ////////////////////////////////////////////////////////////

    initial
    begin : main_seq
        int                   num_recs;
        int                   rec;
        int                   base;
        int                   delay;
        int                   extra;
        int                   max_delay;
        int                   max_extra;
        logic [1:0]           kind;
        logic                 rec_err;
        logic                 sticky_err;                // Model of the error flag
        ifu_pkg::pc_t         next_pc;
        ifu_pkg::pc_t         issued_pc;
        ifu_pkg::pc_t         last_pc;
        ifu_pkg::pc_t         exp_d;
        ifu_pkg::pc_t         exp_x;
        ifu_pkg::pc_t         exp_m;
        ifu_pkg::fetch_word_t last_word;

        rst_n_i  = 1'b0;
        stall    = '1;
        branch_x = '0;
        branch_m = '0;
        wb_rsp   = '0;
        $readmemh("ifu_stim.txt", stim_mem);
        num_recs = count_records();
        if (num_recs == 0)
        begin
            $display("No stimulus records could be read from ifu_stim.txt");
            $display("TEST FAILED");
            $fatal(1, "Empty stimulus");
        end
        max_delay = 0;
        max_extra = 0;
        for (rec = 0; rec < num_recs; rec++)
        begin
            if (stim_mem[rec*REC_WORDS+F_DELAY] > max_delay)
                max_delay = stim_mem[rec*REC_WORDS+F_DELAY];
            if (stim_mem[rec*REC_WORDS+F_EXTRA] > max_extra)
                max_extra = stim_mem[rec*REC_WORDS+F_EXTRA];
        end
        cycle_limit = num_recs * (max_delay + max_extra + 4) + RESET_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        // Idle bus and cleared pipeline out of reset
        check_req("wb_req_o", wb_req, bus_read_req(1'b0, '0));
        check_pc("pc_f_o", pc_f, RESET_PC - ifu_pkg::pc_t'(1));
        expect_stage_pcs('0, '0, '0);
        check_pc("stage_pc_o.pc_w", stage_pc.pc_w, '0);

        sticky_err = 1'b0;
        last_pc    = '0;
        last_word  = '0;
        exp_d      = '0;
        exp_x      = '0;
        exp_m      = '0;

        // Last pass only releases the final word into D
        for (rec = 0; rec <= num_recs; rec++)
        begin
            base = rec * REC_WORDS;
            kind = (rec < num_recs) ? stim_mem[base+F_KIND][1:0] : 2'b00;

            ////////////////////////////////////////////////////////////
            // Release cycle, launches the next fetch
            ////////////////////////////////////////////////////////////
            stall           = '0;
            branch_x.taken  = kind[0];
            branch_m.taken  = kind[1];
            branch_x.target = (rec < num_recs) ? ifu_pkg::pc_t'(stim_mem[base+F_X_TGT]) : '0;
            branch_m.target = (rec < num_recs) ? ifu_pkg::pc_t'(stim_mem[base+F_M_TGT]) : '0;

            if (kind[1])
                next_pc = branch_m.target;               // M wins over X
            else if (kind[0])
                next_pc = branch_x.target;
            else if (rec == 0)
                next_pc = RESET_PC;
            else
                next_pc = last_pc + ifu_pkg::pc_t'(1);
            fetch_q.push_back(next_pc);

            exp_m = exp_x;                               // All stages advance together
            exp_x = exp_d;
            exp_d = (rec == 0) ? RESET_PC - ifu_pkg::pc_t'(1) : last_pc;
            if (kind != 2'b00)
                sticky_err = 1'b0;                       // Cleared after D took the old word

            @(negedge clk_i);
            stall    = '1;
            branch_x = '0;
            branch_m = '0;
            expect_stage_pcs(exp_d, exp_x, exp_m);
            if (rec > 0)
                check_word("instr_d_o", instr_d, last_word);
            issued_pc = fetch_q.pop_front();
            check_req("wb_req_o", wb_req, bus_read_req(1'b1, issued_pc));
            check_pc("pc_f_o", pc_f, issued_pc);

            if (rec < num_recs)
            begin
                ////////////////////////////////////////////////////////////
                // Slave answers after the record's delay
                ////////////////////////////////////////////////////////////
                rec_err = stim_mem[base+F_ERR][0];
                delay   = stim_mem[base+F_DELAY];
                extra   = stim_mem[base+F_EXTRA];
                repeat (delay)
                begin
                    @(negedge clk_i);
                    check_req("wb_req_o", wb_req, bus_read_req(1'b1, issued_pc)); // Held
                    check_pc("pc_f_o", pc_f, issued_pc);
                end
                wb_rsp.dat = stim_mem[base+F_WORD];      // Driven on err too
                wb_rsp.ack = !rec_err;
                wb_rsp.err = rec_err;
                @(negedge clk_i);
                wb_rsp = '0;
                check_req("wb_req_o", wb_req, bus_read_req(1'b0, issued_pc));

                sticky_err          = sticky_err | rec_err;
                last_word.instr     = stim_mem[base+F_WORD];
                last_word.bus_error = sticky_err;
                last_pc             = issued_pc;
                repeat (extra) @(negedge clk_i);         // Core side hold
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- wb_fetch_master.sv
////////////////////////////////////////////////////////////
// Single classic Wishbone reads, one per instruction
// No retry, no burst, rty is not looked at
// bus_error is sticky until a taken branch while idle
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module wb_fetch_master (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                stall_a_i,        // A stage stalled, no new read
    input  wire ifu_pkg::pc_t        pc_a_i,           // Word address to fetch
    input  wire logic                branch_x_taken_i, // Only used to clear error
    input  wire logic                branch_m_taken_i,
    input  wire ifu_pkg::wb_rsp_t    wb_rsp_i,
    output ifu_pkg::wb_req_t         wb_req_o,
    output ifu_pkg::fetch_word_t     fetch_f_o         // Last fetched word
);

    ifu_pkg::fetch_state_e state_q;
    logic [ifu_pkg::WORD_W-1:0] adr_q;             // Byte address of current read
    ifu_pkg::word_t        word_q;                 // Captured instruction
    logic                  bus_error_q;
    logic                  start;                  // Launch a read this edge
    logic                  done;                   // Slave ends the cycle
    logic                  branch_taken;

    ////////////////////////////////////////////////////////////
    // Handshake decode
    ////////////////////////////////////////////////////////////

    assign start        = (state_q == ifu_pkg::FETCH_IDLE) && !stall_a_i;
    assign done         = (state_q == ifu_pkg::FETCH_BUSY)
                          && (wb_rsp_i.ack || wb_rsp_i.err);
    assign branch_taken = branch_x_taken_i || branch_m_taken_i;

    ////////////////////////////////////////////////////////////
    // Bus FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q <= ifu_pkg::FETCH_IDLE;
            adr_q   <= '0;
        end
        else
        begin
            case (state_q)
                ifu_pkg::FETCH_IDLE:
                begin
                    if (start)
                    begin
                        state_q <= ifu_pkg::FETCH_BUSY;
                        adr_q   <= {pc_a_i, {ifu_pkg::BYTE_OFS_W{1'b0}}}; // Word aligned
                    end
                end
                ifu_pkg::FETCH_BUSY:
                begin
                    if (done)
                        state_q <= ifu_pkg::FETCH_IDLE; // cyc drops here
                end
                default: state_q <= ifu_pkg::FETCH_IDLE;
            endcase
        end
    end

    // cyc and stb straight from the state flop
    assign wb_req_o.cyc = (state_q == ifu_pkg::FETCH_BUSY);
    assign wb_req_o.stb = (state_q == ifu_pkg::FETCH_BUSY);
    assign wb_req_o.adr = adr_q;

    ////////////////////////////////////////////////////////////
    // Data and error capture
    ////////////////////////////////////////////////////////////

    // Word is cleared on reset so an early D load sees zero
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            word_q      <= '0;
            bus_error_q <= 1'b0;
        end
        else
        begin
            if (done)
            begin
                word_q <= wb_rsp_i.dat;            // Garbage on err, flag marks it
                if (wb_rsp_i.err)
                    bus_error_q <= 1'b1;
            end
            // Exception entry, let the handler fetch cleanly
            else if ((state_q == ifu_pkg::FETCH_IDLE) && branch_taken)
                bus_error_q <= 1'b0;
        end
    end

    assign fetch_f_o.instr     = word_q;
    assign fetch_f_o.bus_error = bus_error_q;

    ////////////////////////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////////////////////////

    a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_req_o.stb |-> wb_req_o.cyc);

    // Address held until the slave terminates
    a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_req_o.cyc && !(wb_rsp_i.ack || wb_rsp_i.err)) |=> $stable(wb_req_o.adr));

endmodule

`default_nettype wire
